// File: hw/cdb_pkg.sv
`default_nettype none

package cdb_pkg;

    // Two results can be broadcast per cycle
    localparam int unsigned cdb_width = 2;

    // One result slot per function unit feeding the bus
    localparam int unsigned num_fu = 6;

    // Physical register naming
    localparam int unsigned tag_width = 6;
    localparam int unsigned num_phys = 64;

    // Width of a computed result
    localparam int unsigned data_width = 32;

    // Each slot can hold this many finished results while waiting for the bus
    localparam int unsigned slot_depth = 2;

    // Pointer and occupancy widths for the slot queue
    localparam int unsigned slot_ptr_width = (slot_depth > 1) ? $clog2(slot_depth) : 1;
    localparam int unsigned slot_count_width = $clog2(slot_depth + 1);

    // Function unit numbering, used as the index into every per-unit vector
    localparam int unsigned fu_branch = 0;
    localparam int unsigned fu_alu0 = 1;
    localparam int unsigned fu_alu1 = 2;
    localparam int unsigned fu_mem = 3;
    localparam int unsigned fu_mult0 = 4;
    localparam int unsigned fu_mult1 = 5;

    // Bus priority, highest first
    // Branches resolve first so that recovery is never starved by long-latency units
    localparam int unsigned fu_priority [num_fu] = '{
        fu_branch,
        fu_alu0,
        fu_alu1,
        fu_mem,
        fu_mult0,
        fu_mult1
    };

endpackage

`default_nettype wire

// File: hw/psel_gen.sv
`timescale 1ns/10ps
`default_nettype none

// Fixed-priority selector that picks up to reqs requests per cycle
// Index 0 has the highest priority
module psel_gen #(
    parameter int unsigned width = 6,
    parameter int unsigned reqs = 2
) (
    input  logic [width-1:0]           req,
    output logic [width-1:0]           gnt,
    output logic [reqs-1:0][width-1:0] gnt_bus
);

    // Requests still competing after earlier lanes have taken their winners
    logic [reqs:0][width-1:0] remaining;

    always_comb begin
        remaining[0] = req;
        gnt = '0;
        for (int lane = 0; lane < reqs; lane++) begin
            // Two's complement trick isolates the lowest set bit
            // This is the highest-priority request left for this lane
            gnt_bus[lane] = remaining[lane] & (~remaining[lane] + width'(1));

            // Knock the winner out so the next lane searches past it
            remaining[lane + 1] = remaining[lane] & ~gnt_bus[lane];

            // Flat grant is simply the union of all lane winners
            gnt = gnt | gnt_bus[lane];
        end
    end

    // With fewer requests than lanes the upper lanes come out all zero,
    // so every lane bus stays one-hot or empty

endmodule

`default_nettype wire

// File: hw/cdb.sv
`timescale 1ns/10ps
`default_nettype none

// Result bus arbiter and broadcast register
// Grants issued in cycle t select slot outputs in t+1 and reach the bus in t+2
module cdb import cdb_pkg::*; (
    input  logic                                  clock,
    input  logic                                  reset,

    // Per-unit bus requests and the grants returned to the slots
    input  logic [num_fu-1:0]                     request,
    output logic [num_fu-1:0]                     grant,

    // Slot output registers, valid one cycle after their grant
    input  logic [num_fu-1:0]                     out_valid,
    input  logic [num_fu-1:0][tag_width-1:0]      out_tag,
    input  logic [num_fu-1:0][data_width-1:0]     out_value,

    // Tags that will be on the bus next cycle, for early wakeup
    output logic [cdb_width-1:0]                  early_valid,
    output logic [cdb_width-1:0][tag_width-1:0]   early_tag,

    // Registered broadcast lanes
    output logic [cdb_width-1:0]                  cdb_valid,
    output logic [cdb_width-1:0][tag_width-1:0]   cdb_tag,
    output logic [cdb_width-1:0][data_width-1:0]  cdb_value
);

    // Requests and grants rearranged into priority order for the selector
    logic [num_fu-1:0] req_ordered;
    logic [num_fu-1:0] gnt_ordered;

    // Lane grant buses straight from the selector and one cycle later
    logic [cdb_width-1:0][num_fu-1:0] gnt_bus_next;
    logic [cdb_width-1:0][num_fu-1:0] gnt_bus;

    // Lane contents before the broadcast register
    logic [cdb_width-1:0]                 lane_valid;
    logic [cdb_width-1:0][tag_width-1:0]  lane_tag;
    logic [cdb_width-1:0][data_width-1:0] lane_value;

    // Map unit numbers to priority positions and grants back again
    always_comb begin
        grant = '0;
        for (int p = 0; p < num_fu; p++) begin
            req_ordered[p] = request[fu_priority[p]];
            grant[fu_priority[p]] = gnt_ordered[p];
        end
    end

    psel_gen #(
        .width (num_fu),
        .reqs  (cdb_width)
    ) cdb_arbiter (
        .req     (req_ordered),
        .gnt     (gnt_ordered),
        .gnt_bus (gnt_bus_next)
    );

    // The registered grant buses are one-hot per lane, so an OR mux is enough
    always_comb begin
        lane_valid = '0;
        lane_tag = '0;
        lane_value = '0;
        for (int lane = 0; lane < cdb_width; lane++) begin
            for (int p = 0; p < num_fu; p++) begin
                if (gnt_bus[lane][p]) begin
                    lane_valid[lane] |= out_valid[fu_priority[p]];
                    lane_tag[lane] |= out_tag[fu_priority[p]];
                    lane_value[lane] |= out_value[fu_priority[p]];
                end
            end
        end
    end

    // Wakeup sees the lane tags a cycle before the broadcast register does
    assign early_valid = lane_valid;
    assign early_tag = lane_tag;

    always_ff @(posedge clock) begin
        if (reset) begin
            gnt_bus <= '0;
            cdb_valid <= '0;
        end else begin
            gnt_bus <= gnt_bus_next;
            cdb_valid <= lane_valid;
        end
    end

    // Tag and value only mean something when the matching valid is set
    always_ff @(posedge clock) begin
        cdb_tag <= lane_tag;
        cdb_value <= lane_value;
    end

endmodule

`default_nettype wire

// File: hw/fu_result_slot.sv
`timescale 1ns/10ps
`default_nettype none

// Small queue of finished results for one function unit
// The head is handed to the bus output register on a grant
module fu_result_slot import cdb_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,

    // Results arriving from the execution unit
    input  logic                  produce_valid,
    input  logic [tag_width-1:0]  produce_tag,
    input  logic [data_width-1:0] produce_value,
    output logic                  produce_ready,

    // Bus arbitration
    output logic                  request,
    input  logic                  grant,

    // Granted result, held for exactly one cycle
    output logic                  out_valid,
    output logic [tag_width-1:0]  out_tag,
    output logic [data_width-1:0] out_value
);

    logic [tag_width-1:0]        tag_mem [slot_depth];
    logic [data_width-1:0]       value_mem [slot_depth];
    logic [slot_ptr_width-1:0]   wr_ptr;
    logic [slot_ptr_width-1:0]   rd_ptr;
    logic [slot_count_width-1:0] count;

    logic empty;
    logic push;
    logic pop;
    logic write_fifo;
    logic read_fifo;

    function automatic logic [slot_ptr_width-1:0] next_ptr(
        input logic [slot_ptr_width-1:0] ptr
    );
        if (ptr == slot_ptr_width'(slot_depth - 1)) begin
            return '0;
        end
        return ptr + slot_ptr_width'(1);
    endfunction

    assign empty = (count == '0);
    assign produce_ready = (count != slot_count_width'(slot_depth));
    assign push = produce_valid & produce_ready;

    // An incoming result also raises the request, so an empty slot can win the
    // bus in the same cycle the result arrives
    assign request = ~empty | push;
    assign pop = grant & request;

    // When empty, a granted arrival skips the storage and goes straight out
    assign write_fifo = push & ~(pop & empty);
    assign read_fifo = pop & ~empty;

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            out_valid <= 1'b0;
        end else begin
            if (write_fifo) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (read_fifo) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Occupancy only moves when exactly one side acts
            if (write_fifo && !read_fifo) begin
                count <= count + slot_count_width'(1);
            end else if (read_fifo && !write_fifo) begin
                count <= count - slot_count_width'(1);
            end
            out_valid <= pop;
        end
    end

    always_ff @(posedge clock) begin
        if (write_fifo) begin
            tag_mem[wr_ptr] <= produce_tag;
            value_mem[wr_ptr] <= produce_value;
        end
        if (pop) begin
            out_tag <= empty ? produce_tag : tag_mem[rd_ptr];
            out_value <= empty ? produce_value : value_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: hw/ready_table.sv
`timescale 1ns/10ps
`default_nettype none

// One ready bit per physical register
// Early bus tags set the bit so dependents can wake a cycle ahead of the data
module ready_table import cdb_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,

    // Wakeup from the bus, one cycle before the broadcast
    input  logic [cdb_width-1:0]                early_valid,
    input  logic [cdb_width-1:0][tag_width-1:0] early_tag,

    // Newly allocated destination register becomes pending
    input  logic                                alloc_valid,
    input  logic [tag_width-1:0]                alloc_tag,

    // Lookup port
    input  logic [tag_width-1:0]                read_tag,
    output logic                                read_ready
);

    logic [num_phys-1:0] ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            // Architectural state starts out fully available
            ready <= '1;
        end else begin
            for (int lane = 0; lane < cdb_width; lane++) begin
                if (early_valid[lane]) begin
                    ready[early_tag[lane]] <= 1'b1;
                end
            end
            // Placed last so that a clash with a wakeup leaves the bit clear
            if (alloc_valid) begin
                ready[alloc_tag] <= 1'b0;
            end
        end
    end

    assign read_ready = ready[read_tag];

endmodule

`default_nettype wire

// File: hw/phys_regfile.sv
`timescale 1ns/10ps
`default_nettype none

// Physical register file written from both bus lanes
module phys_regfile import cdb_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset,

    // Broadcast lanes
    input  logic [cdb_width-1:0]                 cdb_valid,
    input  logic [cdb_width-1:0][tag_width-1:0]  cdb_tag,
    input  logic [cdb_width-1:0][data_width-1:0] cdb_value,

    // Asynchronous read port
    input  logic [tag_width-1:0]                 read_tag,
    output logic [data_width-1:0]                read_value
);

    logic [data_width-1:0] regs [num_phys];

    // Lanes never carry the same tag, so the write order does not matter
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < num_phys; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int lane = 0; lane < cdb_width; lane++) begin
                if (cdb_valid[lane]) begin
                    regs[cdb_tag[lane]] <= cdb_value[lane];
                end
            end
        end
    end

    // No bypass, so a value written this cycle is visible next cycle
    assign read_value = regs[read_tag];

endmodule

`default_nettype wire

// File: hw/cdb_top.sv
`timescale 1ns/10ps
`default_nettype none

// Result broadcast subsystem
// Six result slots compete for two bus lanes that feed the ready table
// and the physical register file
module cdb_top import cdb_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset,

    // Finished results, one port per function unit
    input  logic [num_fu-1:0]                    produce_valid,
    input  logic [num_fu-1:0][tag_width-1:0]     produce_tag,
    input  logic [num_fu-1:0][data_width-1:0]    produce_value,
    output logic [num_fu-1:0]                    produce_ready,

    // Destination allocation from rename
    input  logic                                 alloc_valid,
    input  logic [tag_width-1:0]                 alloc_tag,

    // Early wakeup and registered broadcast
    output logic [cdb_width-1:0]                 early_valid,
    output logic [cdb_width-1:0][tag_width-1:0]  early_tag,
    output logic [cdb_width-1:0]                 cdb_valid,
    output logic [cdb_width-1:0][tag_width-1:0]  cdb_tag,
    output logic [cdb_width-1:0][data_width-1:0] cdb_value,

    // Shared lookup of ready state and register value
    input  logic [tag_width-1:0]                 read_tag,
    output logic                                 read_ready,
    output logic [data_width-1:0]                read_value
);

    // Slot to bus arbitration and slot output registers
    logic [num_fu-1:0]                request;
    logic [num_fu-1:0]                grant;
    logic [num_fu-1:0]                out_valid;
    logic [num_fu-1:0][tag_width-1:0] out_tag;
    logic [num_fu-1:0][data_width-1:0] out_value;

    // Every slot is identical; only its position in the vectors sets priority
    for (genvar fu = 0; fu < num_fu; fu++) begin : g_slot
        fu_result_slot slot (
            .clock         (clock),
            .reset         (reset),
            .produce_valid (produce_valid[fu]),
            .produce_tag   (produce_tag[fu]),
            .produce_value (produce_value[fu]),
            .produce_ready (produce_ready[fu]),
            .request       (request[fu]),
            .grant         (grant[fu]),
            .out_valid     (out_valid[fu]),
            .out_tag       (out_tag[fu]),
            .out_value     (out_value[fu])
        );
    end

    cdb cdb0 (
        .clock       (clock),
        .reset       (reset),
        .request     (request),
        .grant       (grant),
        .out_valid   (out_valid),
        .out_tag     (out_tag),
        .out_value   (out_value),
        .early_valid (early_valid),
        .early_tag   (early_tag),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

    // Ready bits follow the early tags so they lead the register write by a cycle
    ready_table ready_table0 (
        .clock       (clock),
        .reset       (reset),
        .early_valid (early_valid),
        .early_tag   (early_tag),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .read_tag    (read_tag),
        .read_ready  (read_ready)
    );

    phys_regfile regfile0 (
        .clock      (clock),
        .reset      (reset),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .read_tag   (read_tag),
        .read_value (read_value)
    );

endmodule

`default_nettype wire

// File: test/cdb_top_props.sv
`timescale 1ns/10ps
`default_nettype none

// Bus arbitration and wakeup timing rules, watched on the top level
module cdb_top_props import cdb_pkg::*; (
    input logic                                clock,
    input logic                                reset,
    input logic [num_fu-1:0]                   request,
    input logic [num_fu-1:0]                   grant,
    input logic [cdb_width-1:0]                early_valid,
    input logic [cdb_width-1:0][tag_width-1:0] early_tag,
    input logic [cdb_width-1:0]                cdb_valid,
    input logic [cdb_width-1:0][tag_width-1:0] cdb_tag
);

    // Set when a request is passed over while a lower priority unit wins
    logic skipped;

    always_comb begin
        skipped = 1'b0;
        for (int fu = 0; fu < num_fu; fu++) begin
            if (request[fu] && !grant[fu] && ((grant >> (fu + 1)) != '0)) begin
                skipped = 1'b1;
            end
        end
    end

    grant_count: assert property (@(posedge clock) disable iff (reset)
        $countones(grant) <= cdb_width)
        else $error("More slots granted than there are bus lanes");

    grant_requested: assert property (@(posedge clock) disable iff (reset)
        (grant & ~request) == '0)
        else $error("Grant given to a slot that is not requesting");

    grant_order: assert property (@(posedge clock) disable iff (reset)
        !skipped)
        else $error("Higher priority request skipped by the selector");

    // Every grant shows up as one early lane in the following cycle
    wakeup_count: assert property (@(posedge clock) disable iff (reset)
        $countones(early_valid) == $past($countones(grant)))
        else $error("Early lane count does not match the previous grants");

    // Lane 0 always fills first
    lane_fill: assert property (@(posedge clock) disable iff (reset)
        early_valid[1] |-> early_valid[0])
        else $error("Lane 1 used while lane 0 is idle");

    for (genvar lane = 0; lane < cdb_width; lane++) begin : g_lane
        early_to_bus: assert property (@(posedge clock) disable iff (reset)
            early_valid[lane] |=> cdb_valid[lane] && (cdb_tag[lane] == $past(early_tag[lane])))
            else $error("Early tag not broadcast on the same lane a cycle later");

        bus_needs_early: assert property (@(posedge clock) disable iff (reset)
            !early_valid[lane] |=> !cdb_valid[lane])
            else $error("Broadcast without an early tag in the previous cycle");
    end

endmodule

bind cdb_top cdb_top_props props0 (
    .clock       (clock),
    .reset       (reset),
    .request     (request),
    .grant       (grant),
    .early_valid (early_valid),
    .early_tag   (early_tag),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag)
);

`default_nettype wire

// File: test/cdb_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cdb_top_tb import cdb_pkg::*; ();

    logic                                 clock;
    logic                                 reset;
    logic [num_fu-1:0]                    produce_valid;
    logic [num_fu-1:0][tag_width-1:0]     produce_tag;
    logic [num_fu-1:0][data_width-1:0]    produce_value;
    logic [num_fu-1:0]                    produce_ready;
    logic                                 alloc_valid;
    logic [tag_width-1:0]                 alloc_tag;
    logic [cdb_width-1:0]                 early_valid;
    logic [cdb_width-1:0][tag_width-1:0]  early_tag;
    logic [cdb_width-1:0]                 cdb_valid;
    logic [cdb_width-1:0][tag_width-1:0]  cdb_tag;
    logic [cdb_width-1:0][data_width-1:0] cdb_value;
    logic [tag_width-1:0]                 read_tag;
    logic                                 read_ready;
    logic [data_width-1:0]                read_value;

    // Scoreboard entries indexed by physical tag
    logic [data_width-1:0] expected_value [num_phys];
    bit                    in_flight [num_phys];
    int                    tag_unit [num_phys];
    int                    issue_cycle [num_phys];
    int                    bcast_cycle [num_phys];
    int                    bcast_lane [num_phys];

    // Per unit bookkeeping
    int                    unit_pending [num_fu];
    bit                    saw_full [num_fu];
    logic [tag_width-1:0]  last_tag [num_fu];

    logic [31:0]           rng_state = 32'd15;
    logic [tag_width-1:0]  next_tag = '0;
    int                    cycle_count = 0;
    int                    error_count = 0;
    int                    timeout_count = 0;

    cdb_top dut0 (
        .clock         (clock),
        .reset         (reset),
        .produce_valid (produce_valid),
        .produce_tag   (produce_tag),
        .produce_value (produce_value),
        .produce_ready (produce_ready),
        .alloc_valid   (alloc_valid),
        .alloc_tag     (alloc_tag),
        .early_valid   (early_valid),
        .early_tag     (early_tag),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .read_tag      (read_tag),
        .read_ready    (read_ready),
        .read_value    (read_value)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Cycle number as seen between rising edges
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int total_pending();
        int sum;
        sum = 0;
        for (int fu = 0; fu < num_fu; fu++) begin
            sum += unit_pending[fu];
        end
        return sum;
    endfunction

    task automatic note_failure(input string msg);
        error_count++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("Errors: %0d failed checks, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // Next tag that is not currently held by any slot
    task automatic pick_tag(output logic [tag_width-1:0] tag);
        int tries;
        tries = 0;
        while (in_flight[next_tag] && tries < num_phys) begin
            next_tag = next_tag + tag_width'(1);
            tries++;
        end
        tag = next_tag;
        next_tag = next_tag + tag_width'(1);
    endtask

    // Called on a rising edge, so the result is offered in the following cycle
    task automatic register_result(input int fu, input logic [tag_width-1:0] tag);
        rng_state = xorshift32(rng_state);
        expected_value[tag] = rng_state;
        in_flight[tag] = 1'b1;
        tag_unit[tag] = fu;
        issue_cycle[tag] = cycle_count + 1;
        unit_pending[fu]++;
        last_tag[fu] = tag;
        produce_tag[fu] <= tag;
        produce_value[fu] <= rng_state;
    endtask

    // Ready is read in a cycle with no produce, and can only rise before the next one
    task automatic issue_results(input logic [num_fu-1:0] want);
        logic [num_fu-1:0]    mask;
        logic [tag_width-1:0] tag;
        @(negedge clock);
        mask = want & produce_ready;
        @(posedge clock);
        for (int fu = 0; fu < num_fu; fu++) begin
            if (mask[fu]) begin
                pick_tag(tag);
                register_result(fu, tag);
            end
        end
        produce_valid <= mask;
        @(posedge clock);
        produce_valid <= '0;
    endtask

    task automatic issue_tagged(input int fu, input logic [tag_width-1:0] tag);
        @(posedge clock);
        register_result(fu, tag);
        produce_valid[fu] <= 1'b1;
        @(posedge clock);
        produce_valid <= '0;
    endtask

    // Returns on the first rising edge after the last outstanding broadcast
    // Gives up after max_cycles and counts a timeout if results are still pending
    task automatic wait_idle(input int max_cycles);
        int waited;
        waited = 0;
        while (total_pending() != 0 && waited < max_cycles) begin
            @(posedge clock);
            waited++;
        end
        if (total_pending() != 0) begin
            timeout_count++;
            $display("Timeout after %0d cycles with %0d results never broadcast",
                     max_cycles, total_pending());
        end
    endtask

    task automatic check_broadcast(input int lane, input logic [tag_width-1:0] tag,
                                   input logic [data_width-1:0] value);
        assert (in_flight[tag])
            else note_failure($sformatf("lane %0d broadcast tag %0d not in flight", lane, tag));
        if (in_flight[tag]) begin
            assert (value == expected_value[tag])
                else note_failure($sformatf("tag %0d value %h, expected %h",
                                            tag, value, expected_value[tag]));
            in_flight[tag] = 1'b0;
            unit_pending[tag_unit[tag]]--;
            bcast_cycle[tag] = cycle_count;
            bcast_lane[tag] = lane;
        end
    endtask

    // Allocate, see not ready, produce, then see ready with the new value at t+3
    task automatic check_ready_round(input logic [tag_width-1:0] tag);
        @(posedge clock);
        alloc_valid <= 1'b1;
        alloc_tag <= tag;
        read_tag <= tag;
        @(posedge clock);
        alloc_valid <= 1'b0;
        @(negedge clock);
        assert (!read_ready) else note_failure($sformatf("tag %0d ready after alloc", tag));
        issue_tagged(fu_alu1, tag);
        wait_idle(20);
        @(negedge clock);
        assert (read_ready) else note_failure($sformatf("tag %0d not ready", tag));
        assert (read_value == expected_value[tag])
            else note_failure($sformatf("tag %0d reads %h, expected %h",
                                        tag, read_value, expected_value[tag]));
    endtask

    // Outputs are sampled on the falling edge where they are settled
    always @(negedge clock) begin
        if (!reset) begin
            for (int lane = 0; lane < cdb_width; lane++) begin
                if (cdb_valid[lane]) begin
                    check_broadcast(lane, cdb_tag[lane], cdb_value[lane]);
                end
            end
            // A full slot must hold two results that have not yet been broadcast
            for (int fu = 0; fu < num_fu; fu++) begin
                if (!produce_ready[fu]) begin
                    saw_full[fu] = 1'b1;
                    assert (unit_pending[fu] >= int'(slot_depth))
                        else note_failure($sformatf("unit %0d not ready with %0d pending",
                                                    fu, unit_pending[fu]));
                end
            end
        end
    end

    initial begin
        reset = 1'b1;
        produce_valid = '0;
        produce_tag = '0;
        produce_value = '0;
        alloc_valid = 1'b0;
        alloc_tag = '0;
        read_tag = '0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        @(negedge clock);
        assert (early_valid == '0 && cdb_valid == '0)
            else note_failure("bus active after reset");
        assert (read_ready && read_value == '0)
            else note_failure("register 0 not ready and zero after reset");

        // Lone results reach the bus two cycles after they are offered
        for (int fu = 0; fu < num_fu; fu++) begin
            issue_results(num_fu'(1) << fu);
            wait_idle(20);
            assert (bcast_cycle[last_tag[fu]] == issue_cycle[last_tag[fu]] + 2)
                else note_failure($sformatf("unit %0d result late on the bus", fu));
            assert (bcast_lane[last_tag[fu]] == 0)
                else note_failure($sformatf("unit %0d lone result not on lane 0", fu));
        end

        // All six at once drain in unit order, two per cycle
        issue_results('1);
        wait_idle(20);
        for (int fu = 0; fu < num_fu; fu++) begin
            assert (bcast_cycle[last_tag[fu]] == issue_cycle[last_tag[fu]] + 2 + fu / 2)
                else note_failure($sformatf("unit %0d broadcast out of priority order", fu));
            assert (bcast_lane[last_tag[fu]] == fu % 2)
                else note_failure($sformatf("unit %0d broadcast on the wrong lane", fu));
        end

        // Keep every unit busy so the multipliers starve and fill up
        for (int fu = 0; fu < num_fu; fu++) begin
            saw_full[fu] = 1'b0;
        end
        repeat (8) issue_results('1);
        wait_idle(60);
        assert (saw_full[fu_mult1]) else note_failure("mult1 never applied back-pressure");
        assert (saw_full[fu_mult0]) else note_failure("mult0 never applied back-pressure");

        // Random mixes of producing units
        repeat (40) begin
            rng_state = xorshift32(rng_state);
            issue_results(rng_state[num_fu-1:0]);
        end
        wait_idle(100);

        // Two rounds on one tag, so the second allocation follows a broadcast
        check_ready_round(6'd42);
        check_ready_round(6'd42);

        finish_run();
    end

endmodule

`default_nettype wire

// File: cdb_top.f
hw/cdb_pkg.sv
hw/psel_gen.sv
hw/cdb.sv
hw/fu_result_slot.sv
hw/ready_table.sv
hw/phys_regfile.sv
hw/cdb_top.sv
test/cdb_top_props.sv
test/cdb_top_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the result broadcast regression with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module cdb_top_tb -f cdb_top.f --Mdir obj_dir -o cdb_sim

status=0
./obj_dir/cdb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Regression passed" sim.log; then
    echo "Simulation stopped early or did not complete"
    exit 1
fi
